// ==== include/mcast_xbar_consts.svh ====
// Crossbar sizing constants, included by every RTL and testbench file that needs them
`ifndef MCAST_XBAR_CONSTS_SVH
`define MCAST_XBAR_CONSTS_SVH

// Number of request ports
`define MCX_NUM_SLV 2

// Number of destination ports
`define MCX_NUM_MST 4

// Address and multicast mask width
`define MCX_ADDR_W 32

// Data word width
`define MCX_DATA_W 32

// Receiver buffer depth, also the initial credit count of each sender
`define MCX_CREDITS 4

// Width of the source tag added at the muxes
`define MCX_SRC_W 1

`endif

// ==== verilog/mcast_bus_pkg.sv ====
// Request and forwarded-request types shared by the crossbar blocks and its testbench
`default_nettype none

`include "mcast_xbar_consts.svh"

package mcast_bus_pkg;

  // Index of a request port, carried as source tag on the destination side
  typedef logic [`MCX_SRC_W-1:0] src_idx_t;

  // Write request as seen on a request port
  typedef struct packed {
    logic [`MCX_ADDR_W-1:0] addr;
    // Set bits mark address bits that are free, so one request covers a set of addresses
    logic [`MCX_ADDR_W-1:0] mask;
    logic [`MCX_DATA_W-1:0] data;
  } mcast_req_t;

  // Request leaving a destination port, widened by the source tag
  typedef struct packed {
    mcast_req_t req;
    src_idx_t   src;
  } mcast_fwd_t;

endpackage

`default_nettype wire

// ==== verilog/mcast_addr_pkg.sv ====
// Address map types used by the multicast decoder and fed in at the crossbar top level
`default_nettype none

`include "mcast_xbar_consts.svh"

package mcast_addr_pkg;

  // One region per destination, mask bits set where the address is free
  typedef struct packed {
    logic [`MCX_ADDR_W-1:0] addr;
    logic [`MCX_ADDR_W-1:0] mask;
  } mask_rule_t;

  // Rule j belongs to destination port j
  typedef mask_rule_t [`MCX_NUM_MST-1:0] addr_map_t;

  // One bit per destination port
  typedef logic [`MCX_NUM_MST-1:0] mst_sel_t;

endpackage

`default_nettype wire

// ==== verilog/mcast_addr_decode.sv ====
// Multicast decoder, maps one request onto every destination region it overlaps
`timescale 1ns/1ns
`default_nettype none

`include "mcast_xbar_consts.svh"

module mcast_addr_decode (
  input  mcast_bus_pkg::mcast_req_t                       req_i,
  input  mcast_addr_pkg::addr_map_t                       addr_map_i,
  output mcast_addr_pkg::mst_sel_t                        sel_o,
  output logic [`MCX_NUM_MST-1:0][`MCX_ADDR_W-1:0]        fwd_addr_o,
  output logic [`MCX_NUM_MST-1:0][`MCX_ADDR_W-1:0]        fwd_mask_o,
  output logic                                            dec_err_o
);

  for (genvar j = 0; j < `MCX_NUM_MST; j++) begin : gen_rule
    logic [`MCX_ADDR_W-1:0] fixed_both;
    logic [`MCX_ADDR_W-1:0] differ;

    // Only bits fixed in both the request and the rule have to agree
    assign fixed_both = ~(req_i.mask | addr_map_i[j].mask);
    assign differ     = req_i.addr ^ addr_map_i[j].addr;
    assign sel_o[j]   = ~|(differ & fixed_both);

    // Rule bits win where the rule fixes them
    assign fwd_addr_o[j] = (addr_map_i[j].addr & ~addr_map_i[j].mask) |
                           (req_i.addr & addr_map_i[j].mask);

    // Bits pinned by the region are no longer free in the copy
    assign fwd_mask_o[j] = req_i.mask & addr_map_i[j].mask;
  end

  assign dec_err_o = ~|sel_o;

endmodule

`default_nettype wire

// ==== verilog/mcast_demux.sv ====
// Request port front end: credit buffer, head decode and fan-out to the destination muxes
`timescale 1ns/1ns
`default_nettype none

`include "mcast_xbar_consts.svh"

module mcast_demux #(
  // Tag placed on every copy leaving this port
  parameter int unsigned SrcIdx = 0
) (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic                                             slv_valid_i,
  input  mcast_bus_pkg::mcast_req_t                        slv_req_i,
  output logic                                             slv_credit_o,
  input  mcast_addr_pkg::addr_map_t                        addr_map_i,
  output mcast_addr_pkg::mst_sel_t                         fwd_valid_o,
  output mcast_bus_pkg::mcast_fwd_t [`MCX_NUM_MST-1:0]     fwd_req_o,
  input  mcast_addr_pkg::mst_sel_t                         fwd_grant_i,
  output logic                                             dec_err_o,
  output logic [`MCX_ADDR_W-1:0]                           dec_err_addr_o
);

  localparam int unsigned PtrW = (`MCX_CREDITS > 1) ? $clog2(`MCX_CREDITS) : 1;
  localparam int unsigned CntW = $clog2(`MCX_CREDITS + 1);

  mcast_bus_pkg::mcast_req_t mem_q [0:`MCX_CREDITS-1];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;

  mcast_bus_pkg::mcast_req_t head;
  logic                      head_valid;

  mcast_addr_pkg::mst_sel_t               head_sel;
  logic [`MCX_NUM_MST-1:0][`MCX_ADDR_W-1:0] head_addr;
  logic [`MCX_NUM_MST-1:0][`MCX_ADDR_W-1:0] head_mask;
  logic                                   head_err;

  // Destinations that already took the current head
  mcast_addr_pkg::mst_sel_t done_q;
  mcast_addr_pkg::mst_sel_t pending;
  logic                     retire;

  assign head       = mem_q[rd_ptr_q];
  assign head_valid = (count_q != '0);

  mcast_addr_decode i_decode (
    .req_i      ( head       ),
    .addr_map_i ( addr_map_i ),
    .sel_o      ( head_sel   ),
    .fwd_addr_o ( head_addr  ),
    .fwd_mask_o ( head_mask  ),
    .dec_err_o  ( head_err   )
  );

  assign pending     = head_valid ? (head_sel & ~done_q) : '0;
  assign fwd_valid_o = pending;

  for (genvar j = 0; j < `MCX_NUM_MST; j++) begin : gen_fwd
    assign fwd_req_o[j].req.addr = head_addr[j];
    assign fwd_req_o[j].req.mask = head_mask[j];
    assign fwd_req_o[j].req.data = head.data;
    assign fwd_req_o[j].src      = mcast_bus_pkg::src_idx_t'(SrcIdx);
  end

  // Head leaves once every selected copy is granted, errors leave at once
  assign retire = head_valid & (head_err | ((pending & ~fwd_grant_i) == '0));

  assign slv_credit_o   = retire;
  assign dec_err_o      = head_valid & head_err;
  assign dec_err_addr_o = head.addr;

  always_ff @(posedge clk_i) begin
    if (slv_valid_i) begin
      mem_q[wr_ptr_q] <= slv_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      done_q   <= '0;
    end else begin
      if (slv_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(`MCX_CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (retire) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(`MCX_CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
        done_q   <= '0;
      end else begin
        done_q <= done_q | (fwd_grant_i & pending);
      end
      // Upstream only sends with a credit, so the buffer cannot overflow
      count_q <= count_q + CntW'(slv_valid_i) - CntW'(retire);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mcast_mux.sv ====
// Destination port back end: round-robin pick among request ports, gated by downstream credits
`timescale 1ns/1ns
`default_nettype none

`include "mcast_xbar_consts.svh"

module mcast_mux (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  logic [`MCX_NUM_SLV-1:0]                        req_valid_i,
  input  mcast_bus_pkg::mcast_fwd_t [`MCX_NUM_SLV-1:0]   req_i,
  output logic [`MCX_NUM_SLV-1:0]                        grant_o,
  output logic                                           mst_valid_o,
  output mcast_bus_pkg::mcast_fwd_t                      mst_req_o,
  input  logic                                           mst_credit_i
);

  localparam int unsigned CntW = $clog2(`MCX_CREDITS + 1);

  logic [CntW-1:0]          credit_q;
  mcast_bus_pkg::src_idx_t  last_q;
  mcast_bus_pkg::src_idx_t  win_idx;
  logic                     win_valid;
  logic                     send;

  logic                      valid_q;
  mcast_bus_pkg::mcast_fwd_t req_q;

  // Search starts one past the previous winner
  always_comb begin
    int unsigned cand;
    cand      = 0;
    win_valid = 1'b0;
    win_idx   = last_q;
    for (int unsigned off = 1; off <= `MCX_NUM_SLV; off++) begin
      cand = (int'(last_q) + off) % `MCX_NUM_SLV;
      if (!win_valid && req_valid_i[cand]) begin
        win_valid = 1'b1;
        win_idx   = mcast_bus_pkg::src_idx_t'(cand);
      end
    end
  end

  // No grant without a downstream buffer slot
  assign send = win_valid & (credit_q != '0);

  always_comb begin
    grant_o = '0;
    if (send) begin
      grant_o[win_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= CntW'(`MCX_CREDITS);
      last_q   <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q  <= send;
      credit_q <= credit_q + CntW'(mst_credit_i) - CntW'(send);
      if (send) begin
        last_q <= win_idx;
      end
    end
  end

  // Payload carries its source tag from the demux already
  always_ff @(posedge clk_i) begin
    if (send) begin
      req_q <= req_i[win_idx];
    end
  end

  assign mst_valid_o = valid_q;
  assign mst_req_o   = req_q;

endmodule

`default_nettype wire

// ==== verilog/mcast_xbar.sv ====
// Multicast write crossbar top level, one demux per request port and one mux per destination
`timescale 1ns/1ns
`default_nettype none

`include "mcast_xbar_consts.svh"

module mcast_xbar (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  mcast_addr_pkg::addr_map_t                     addr_map_i,
  input  logic [`MCX_NUM_SLV-1:0]                       slv_valid_i,
  input  mcast_bus_pkg::mcast_req_t [`MCX_NUM_SLV-1:0]  slv_req_i,
  output logic [`MCX_NUM_SLV-1:0]                       slv_credit_o,
  output logic [`MCX_NUM_MST-1:0]                       mst_valid_o,
  output mcast_bus_pkg::mcast_fwd_t [`MCX_NUM_MST-1:0]  mst_req_o,
  input  logic [`MCX_NUM_MST-1:0]                       mst_credit_i,
  output logic [`MCX_NUM_SLV-1:0]                       dec_err_o,
  output logic [`MCX_NUM_SLV-1:0][`MCX_ADDR_W-1:0]      dec_err_addr_o
);

  // Demux side, indexed [source][destination]
  mcast_addr_pkg::mst_sel_t [`MCX_NUM_SLV-1:0]                        fwd_valid;
  mcast_bus_pkg::mcast_fwd_t [`MCX_NUM_SLV-1:0][`MCX_NUM_MST-1:0]     fwd_req;
  mcast_addr_pkg::mst_sel_t [`MCX_NUM_SLV-1:0]                        dmx_grant;

  // Mux side, indexed [destination][source]
  logic [`MCX_NUM_MST-1:0][`MCX_NUM_SLV-1:0]                          mux_valid;
  mcast_bus_pkg::mcast_fwd_t [`MCX_NUM_MST-1:0][`MCX_NUM_SLV-1:0]     mux_req;
  logic [`MCX_NUM_MST-1:0][`MCX_NUM_SLV-1:0]                          fwd_grant;

  for (genvar i = 0; i < `MCX_NUM_SLV; i++) begin : gen_demux
    mcast_demux #(
      .SrcIdx ( i )
    ) i_demux (
      .clk_i          ( clk_i             ),
      .rst_n_i        ( rst_n_i           ),
      .slv_valid_i    ( slv_valid_i[i]    ),
      .slv_req_i      ( slv_req_i[i]      ),
      .slv_credit_o   ( slv_credit_o[i]   ),
      .addr_map_i     ( addr_map_i        ),
      .fwd_valid_o    ( fwd_valid[i]      ),
      .fwd_req_o      ( fwd_req[i]        ),
      .fwd_grant_i    ( dmx_grant[i]      ),
      .dec_err_o      ( dec_err_o[i]      ),
      .dec_err_addr_o ( dec_err_addr_o[i] )
    );
  end

  // Transpose between the two sides
  for (genvar i = 0; i < `MCX_NUM_SLV; i++) begin : gen_cross_slv
    for (genvar j = 0; j < `MCX_NUM_MST; j++) begin : gen_cross_mst
      assign mux_valid[j][i] = fwd_valid[i][j];
      assign mux_req[j][i]   = fwd_req[i][j];
      assign dmx_grant[i][j] = fwd_grant[j][i];
    end
  end

  for (genvar j = 0; j < `MCX_NUM_MST; j++) begin : gen_mux
    mcast_mux i_mux (
      .clk_i        ( clk_i           ),
      .rst_n_i      ( rst_n_i         ),
      .req_valid_i  ( mux_valid[j]    ),
      .req_i        ( mux_req[j]      ),
      .grant_o      ( fwd_grant[j]    ),
      .mst_valid_o  ( mst_valid_o[j]  ),
      .mst_req_o    ( mst_req_o[j]    ),
      .mst_credit_i ( mst_credit_i[j] )
    );
  end

endmodule

`default_nettype wire

// ==== testbench/tb_mcast_xbar.sv ====
// Random-stimulus testbench for the multicast crossbar and compiled with the project file list
`timescale 1ns/1ns
`default_nettype none

`include "mcast_xbar_consts.svh"

module tb_mcast_xbar;

  localparam int NumRand    = 160;
  localparam int NumBp      = 48;
  localparam int TimeoutCyc = 40 * (4 + 2 + 2 + NumRand + NumBp);

  logic                                          clk_i = 1'b0;
  logic                                          rst_n_i;
  mcast_addr_pkg::addr_map_t                     addr_map_i;
  logic [`MCX_NUM_SLV-1:0]                       slv_valid_i;
  mcast_bus_pkg::mcast_req_t [`MCX_NUM_SLV-1:0]  slv_req_i;
  logic [`MCX_NUM_SLV-1:0]                       slv_credit_o;
  logic [`MCX_NUM_MST-1:0]                       mst_valid_o;
  mcast_bus_pkg::mcast_fwd_t [`MCX_NUM_MST-1:0]  mst_req_o;
  logic [`MCX_NUM_MST-1:0]                       mst_credit_i;
  logic [`MCX_NUM_SLV-1:0]                       dec_err_o;
  logic [`MCX_NUM_SLV-1:0][`MCX_ADDR_W-1:0]      dec_err_addr_o;

  // Pending stimulus per source and expected traffic per destination and source
  mcast_bus_pkg::mcast_req_t send_q [`MCX_NUM_SLV][$];
  mcast_bus_pkg::mcast_fwd_t exp_fwd_q [`MCX_NUM_MST][`MCX_NUM_SLV][$];
  logic [`MCX_ADDR_W-1:0]    exp_err_q [`MCX_NUM_SLV][$];
  int                        credit_due_q [`MCX_NUM_MST][$];
  int                        src_cred [`MCX_NUM_SLV];
  int                        sent_cnt [`MCX_NUM_SLV];
  int                        cred_ret_cnt [`MCX_NUM_SLV];
  int                        outstanding [`MCX_NUM_MST];
  int                        cycle_cnt = 0;
  int                        err_cnt = 0;
  int                        test_cnt = 0;
  int                        test_fail_cnt = 0;
  logic        hold_credits;
  logic [31:0] rng_state;
  string       test_name;

  mcast_xbar mcast_xbar_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .addr_map_i     ( addr_map_i     ),
    .slv_valid_i    ( slv_valid_i    ),
    .slv_req_i      ( slv_req_i      ),
    .slv_credit_o   ( slv_credit_o   ),
    .mst_valid_o    ( mst_valid_o    ),
    .mst_req_o      ( mst_req_o      ),
    .mst_credit_i   ( mst_credit_i   ),
    .dec_err_o      ( dec_err_o      ),
    .dec_err_addr_o ( dec_err_addr_o )
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Mostly mapped requests with about one in ten pinning a bit outside every region
  function automatic mcast_bus_pkg::mcast_req_t random_request();
    mcast_bus_pkg::mcast_req_t req;
    logic [31:0] r;
    r = next_rand();
    req.addr = next_rand();
    req.addr[31:30] = (r[2:0] == 3'd0) ? r[4:3] : 2'b00;
    req.mask = next_rand() & 32'h0000_00ff;
    req.mask[29:28] = r[6:5] & {2{r[7]}};
    req.mask[31:30] = (r[10:8] == 3'd0) ? r[12:11] : 2'b00;
    req.data = next_rand();
    return req;
  endfunction

  // Region j pins bits 31:28 to {2'b00, j} and leaves the low 28 bits free
  task automatic expect_request(input int src, input mcast_bus_pkg::mcast_req_t req);
    mcast_bus_pkg::mcast_fwd_t exp;
    logic [1:0] region;
    logic any_hit;
    any_hit = 1'b0;
    for (int j = 0; j < `MCX_NUM_MST; j++) begin
      region = 2'(j);
      if (((req.addr[31:30] & ~req.mask[31:30]) == 2'b00) &&
          (((req.addr[29:28] ^ region) & ~req.mask[29:28]) == 2'b00)) begin
        exp.req.addr = {2'b00, region, req.addr[27:0]};
        exp.req.mask = {4'b0000, req.mask[27:0]};
        exp.req.data = req.data;
        exp.src      = mcast_bus_pkg::src_idx_t'(src);
        exp_fwd_q[j][src].push_back(exp);
        any_hit = 1'b1;
      end
    end
    if (!any_hit) begin
      exp_err_q[src].push_back(req.addr);
    end
  endtask

  task automatic check_outputs();
    int src;
    mcast_bus_pkg::mcast_fwd_t exp;
    logic [`MCX_ADDR_W-1:0] exp_addr;
    for (int j = 0; j < `MCX_NUM_MST; j++) begin
      if (mst_valid_o[j]) begin
        src = int'(mst_req_o[j].src);
        outstanding[j]++;
        credit_due_q[j].push_back(cycle_cnt + 1 + int'(next_rand() % 6));
        if (outstanding[j] > `MCX_CREDITS) begin
          $display("ERROR %s: destination %0d holds %0d requests without credit",
                   test_name, j, outstanding[j]);
          err_cnt++;
        end
        if (exp_fwd_q[j][src].size() == 0) begin
          $display("ERROR %s: destination %0d got an extra request from source %0d",
                   test_name, j, src);
          err_cnt++;
        end else begin
          exp = exp_fwd_q[j][src].pop_front();
          if (mst_req_o[j] !== exp) begin
            $display("MISMATCH %s: dest %0d expected %h actual %h",
                     test_name, j, exp, mst_req_o[j]);
            err_cnt++;
          end
        end
      end
    end
    for (int i = 0; i < `MCX_NUM_SLV; i++) begin
      if (dec_err_o[i]) begin
        if (exp_err_q[i].size() == 0) begin
          $display("ERROR %s: source %0d reported a decode error that was not due", test_name, i);
          err_cnt++;
        end else begin
          exp_addr = exp_err_q[i].pop_front();
          if (dec_err_addr_o[i] !== exp_addr) begin
            $display("MISMATCH %s: error addr expected %h actual %h",
                     test_name, exp_addr, dec_err_addr_o[i]);
            err_cnt++;
          end
        end
      end
      if (slv_credit_o[i]) begin
        src_cred[i]++;
        cred_ret_cnt[i]++;
      end
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    for (int j = 0; j < `MCX_NUM_MST; j++) begin
      mst_credit_i[j] = 1'b0;
      if (!hold_credits && credit_due_q[j].size() != 0 && credit_due_q[j][0] <= cycle_cnt) begin
        mst_credit_i[j] = 1'b1;
        void'(credit_due_q[j].pop_front());
        outstanding[j]--;
      end
    end
    for (int i = 0; i < `MCX_NUM_SLV; i++) begin
      r = next_rand();
      slv_valid_i[i] = 1'b0;
      if (send_q[i].size() != 0 && src_cred[i] > 0 && r[1:0] != 2'b00) begin
        slv_valid_i[i] = 1'b1;
        slv_req_i[i]   = send_q[i].pop_front();
        src_cred[i]--;
        sent_cnt[i]++;
        expect_request(i, slv_req_i[i]);
      end
    end
  endtask

  // Outputs are sampled before the new inputs go out
  always @(negedge clk_i) begin
    check_outputs();
    drive_inputs();
  end

  function automatic bit all_idle();
    for (int i = 0; i < `MCX_NUM_SLV; i++) begin
      if (send_q[i].size() != 0 || exp_err_q[i].size() != 0) begin
        return 1'b0;
      end
      for (int j = 0; j < `MCX_NUM_MST; j++) begin
        if (exp_fwd_q[j][i].size() != 0 || credit_due_q[j].size() != 0) begin
          return 1'b0;
        end
      end
    end
    return 1'b1;
  endfunction

  task automatic finish_test(input int errs_before);
    @(posedge clk_i);
    while (!all_idle()) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: pass", test_name);
    end else begin
      test_fail_cnt++;
      $display("test %s: FAIL with %0d errors", test_name, err_cnt - errs_before);
    end
  endtask

  initial begin
    wait (cycle_cnt >= TimeoutCyc);
    $display("ERROR timeout after %0d cycles in test %s", cycle_cnt, test_name);
    for (int i = 0; i < `MCX_NUM_SLV; i++) begin
      $display("source %0d: %0d left to send, %0d decode errors missing",
               i, send_q[i].size(), exp_err_q[i].size());
      for (int j = 0; j < `MCX_NUM_MST; j++) begin
        $display("destination %0d from source %0d: %0d requests missing",
                 j, i, exp_fwd_q[j][i].size());
      end
    end
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int errs;
    logic [31:0] r;
    mcast_bus_pkg::mcast_req_t req;
    rst_n_i      = 1'b0;
    slv_valid_i  = '0;
    slv_req_i    = '0;
    mst_credit_i = '0;
    hold_credits = 1'b0;
    rng_state    = 32'h9b4ff03c;
    test_name    = "reset";
    for (int j = 0; j < `MCX_NUM_MST; j++) begin
      addr_map_i[j].addr = {2'b00, 2'(j), 28'h0};
      addr_map_i[j].mask = 32'h0fff_ffff;
      outstanding[j]     = 0;
    end
    for (int i = 0; i < `MCX_NUM_SLV; i++) begin
      src_cred[i]     = `MCX_CREDITS;
      sent_cnt[i]     = 0;
      cred_ret_cnt[i] = 0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(posedge clk_i);

    test_name = "unicast";
    errs = err_cnt;
    for (int j = 0; j < `MCX_NUM_MST; j++) begin
      r        = next_rand();
      req.addr = {2'b00, 2'(j), r[27:0]};
      req.mask = '0;
      req.data = next_rand();
      send_q[j % `MCX_NUM_SLV].push_back(req);
    end
    finish_test(errs);

    test_name = "multicast";
    errs = err_cnt;
    for (int i = 0; i < `MCX_NUM_SLV; i++) begin
      r        = next_rand();
      req.addr = {2'b00, r[29:0]};
      req.mask = 32'h3000_0000 | (next_rand() & 32'h0000_0f0f);
      req.data = next_rand();
      send_q[i].push_back(req);
    end
    finish_test(errs);

    test_name = "decode_error";
    errs = err_cnt;
    for (int i = 0; i < `MCX_NUM_SLV; i++) begin
      req.addr = next_rand() | 32'h8000_0000;
      req.mask = '0;
      req.data = next_rand();
      send_q[i].push_back(req);
    end
    finish_test(errs);

    test_name = "concurrent";
    errs = err_cnt;
    for (int n = 0; n < NumRand; n++) begin
      send_q[next_rand() % `MCX_NUM_SLV].push_back(random_request());
    end
    finish_test(errs);

    // Sinks keep their credits until every destination and then every source stalls
    test_name = "back_pressure";
    errs = err_cnt;
    hold_credits = 1'b1;
    for (int n = 0; n < NumBp; n++) begin
      send_q[next_rand() % `MCX_NUM_SLV].push_back(random_request());
    end
    repeat (120) @(posedge clk_i);
    if (src_cred[0] != 0 && src_cred[1] != 0) begin
      $display("ERROR %s: no request port ran out of credits while sinks were held", test_name);
      err_cnt++;
    end
    hold_credits = 1'b0;
    finish_test(errs);

    test_name = "credit_return";
    errs = err_cnt;
    for (int i = 0; i < `MCX_NUM_SLV; i++) begin
      if (cred_ret_cnt[i] != sent_cnt[i]) begin
        $display("MISMATCH %s: source %0d expected %0d actual %0d",
                 test_name, i, sent_cnt[i], cred_ret_cnt[i]);
        err_cnt++;
      end
    end
    finish_test(errs);

    $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mcast_xbar.f ====
+incdir+include
verilog/mcast_bus_pkg.sv
verilog/mcast_addr_pkg.sv
verilog/mcast_addr_decode.sv
verilog/mcast_demux.sv
verilog/mcast_mux.sv
verilog/mcast_xbar.sv
testbench/tb_mcast_xbar.sv

// ==== Bender.yml ====
package:
  name: mcast_xbar

export_include_dirs:
  - include

sources:
  - verilog/mcast_bus_pkg.sv
  - verilog/mcast_addr_pkg.sv
  - verilog/mcast_addr_decode.sv
  - verilog/mcast_demux.sv
  - verilog/mcast_mux.sv
  - verilog/mcast_xbar.sv
  - target: test
    files:
      - testbench/tb_mcast_xbar.sv
